/* include/decode_vectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef enum logic [2:0] {F_3R, F_2RI12, F_1RI20, F_OFFS, F_ZERO} fmt_e;
typedef enum logic [1:0] {P0_NO, P0_RJ, P0_R0} port0_e; // What read port 0 sees
typedef enum logic [1:0] {P1_NO, P1_RK, P1_RD} port1_e;
typedef enum logic [1:0] {W_NO, W_RD, W_R1} wport_e;

typedef struct packed {
    fmt_e        fmt;
    logic [16:0] opcode; // Right-aligned opcode field
    alu_op_e     alu_op;
    alu_sel_e    alu_sel;
    port0_e      p0;
    port1_e      p1;
    wport_e      wr;
    imm_kind_e   imm_kind;
    exc_cause_e  exc_cause;
} vec_t;

localparam int NUM_VECS = 43;

vec_t vec_tbl [NUM_VECS];
int   vec_cnt = 0;

task automatic add_row(input fmt_e fmt, input logic [16:0] opcode, input alu_op_e op,
                       input alu_sel_e sel, input port0_e p0, input port1_e p1,
                       input wport_e wr, input imm_kind_e kind,
                       input exc_cause_e cause = EXC_NONE);
    vec_tbl[vec_cnt] = '{fmt, opcode, op, sel, p0, p1, wr, kind, cause};
    vec_cnt++;
endtask

task automatic load_vectors();
    add_row(F_3R, 17'h020, ALU_ADDW, ALU_SEL_ARITH, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_3R, 17'h022, ALU_SUBW, ALU_SEL_ARITH, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_3R, 17'h024, ALU_SLT, ALU_SEL_ARITH, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_3R, 17'h025, ALU_SLTU, ALU_SEL_ARITH, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_3R, 17'h028, ALU_NOR, ALU_SEL_LOGIC, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_3R, 17'h029, ALU_AND, ALU_SEL_LOGIC, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_3R, 17'h02a, ALU_OR, ALU_SEL_LOGIC, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_3R, 17'h02b, ALU_XOR, ALU_SEL_LOGIC, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_3R, 17'h02e, ALU_SLLW, ALU_SEL_SHIFT, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_3R, 17'h02f, ALU_SRLW, ALU_SEL_SHIFT, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_3R, 17'h030, ALU_SRAW, ALU_SEL_SHIFT, P0_RJ, P1_RK, W_RD, IMM_NONE);
    add_row(F_2RI12, 17'h008, ALU_SLTI, ALU_SEL_ARITH, P0_RJ, P1_NO, W_RD, IMM_SI12);
    add_row(F_2RI12, 17'h009, ALU_SLTUI, ALU_SEL_ARITH, P0_RJ, P1_NO, W_RD, IMM_SI12);
    add_row(F_2RI12, 17'h00a, ALU_ADDIW, ALU_SEL_ARITH, P0_RJ, P1_NO, W_RD, IMM_SI12);
    add_row(F_2RI12, 17'h00d, ALU_ANDI, ALU_SEL_LOGIC, P0_RJ, P1_NO, W_RD, IMM_UI12);
    add_row(F_2RI12, 17'h00e, ALU_ORI, ALU_SEL_LOGIC, P0_RJ, P1_NO, W_RD, IMM_UI12);
    add_row(F_2RI12, 17'h00f, ALU_XORI, ALU_SEL_LOGIC, P0_RJ, P1_NO, W_RD, IMM_UI12);
    add_row(F_3R, 17'h081, ALU_SLLIW, ALU_SEL_SHIFT, P0_RJ, P1_NO, W_RD, IMM_UI5);
    add_row(F_3R, 17'h089, ALU_SRLIW, ALU_SEL_SHIFT, P0_RJ, P1_NO, W_RD, IMM_UI5);
    add_row(F_3R, 17'h091, ALU_SRAIW, ALU_SEL_SHIFT, P0_RJ, P1_NO, W_RD, IMM_UI5);
    add_row(F_1RI20, 17'h00a, ALU_LU12I, ALU_SEL_LOGIC, P0_R0, P1_NO, W_RD, IMM_SI20_HI);
    add_row(F_1RI20, 17'h00e, ALU_PCADDU12I, ALU_SEL_ARITH, P0_RJ, P1_NO, W_RD, IMM_SI20_HI);
    add_row(F_2RI12, 17'h0a0, ALU_LDB, ALU_SEL_LDST, P0_RJ, P1_NO, W_RD, IMM_SI12);
    add_row(F_2RI12, 17'h0a1, ALU_LDH, ALU_SEL_LDST, P0_RJ, P1_NO, W_RD, IMM_SI12);
    add_row(F_2RI12, 17'h0a2, ALU_LDW, ALU_SEL_LDST, P0_RJ, P1_NO, W_RD, IMM_SI12);
    add_row(F_2RI12, 17'h0a8, ALU_LDBU, ALU_SEL_LDST, P0_RJ, P1_NO, W_RD, IMM_SI12);
    add_row(F_2RI12, 17'h0a9, ALU_LDHU, ALU_SEL_LDST, P0_RJ, P1_NO, W_RD, IMM_SI12);
    add_row(F_2RI12, 17'h0a4, ALU_STB, ALU_SEL_LDST, P0_RJ, P1_RD, W_NO, IMM_SI12);
    add_row(F_2RI12, 17'h0a5, ALU_STH, ALU_SEL_LDST, P0_RJ, P1_RD, W_NO, IMM_SI12);
    add_row(F_2RI12, 17'h0a6, ALU_STW, ALU_SEL_LDST, P0_RJ, P1_RD, W_NO, IMM_SI12);
    add_row(F_OFFS, 17'h016, ALU_BEQ, ALU_SEL_BRANCH, P0_RJ, P1_RD, W_NO, IMM_OFFS16);
    add_row(F_OFFS, 17'h017, ALU_BNE, ALU_SEL_BRANCH, P0_RJ, P1_RD, W_NO, IMM_OFFS16);
    add_row(F_OFFS, 17'h018, ALU_BLT, ALU_SEL_BRANCH, P0_RJ, P1_RD, W_NO, IMM_OFFS16);
    add_row(F_OFFS, 17'h019, ALU_BGE, ALU_SEL_BRANCH, P0_RJ, P1_RD, W_NO, IMM_OFFS16);
    add_row(F_OFFS, 17'h01a, ALU_BLTU, ALU_SEL_BRANCH, P0_RJ, P1_RD, W_NO, IMM_OFFS16);
    add_row(F_OFFS, 17'h01b, ALU_BGEU, ALU_SEL_BRANCH, P0_RJ, P1_RD, W_NO, IMM_OFFS16);
    add_row(F_OFFS, 17'h014, ALU_B, ALU_SEL_BRANCH, P0_NO, P1_NO, W_NO, IMM_OFFS26);
    add_row(F_OFFS, 17'h015, ALU_BL, ALU_SEL_BRANCH, P0_NO, P1_NO, W_R1, IMM_OFFS26);
    add_row(F_OFFS, 17'h013, ALU_JIRL, ALU_SEL_BRANCH, P0_RJ, P1_NO, W_RD, IMM_OFFS16);
    add_row(F_3R, 17'h054, ALU_BREAK, ALU_SEL_NOP, P0_NO, P1_NO, W_NO, IMM_NONE, EXC_BRK);
    add_row(F_3R, 17'h056, ALU_SYSCALL, ALU_SEL_NOP, P0_NO, P1_NO, W_NO, IMM_NONE, EXC_SYS);
    add_row(F_OFFS, 17'h03f, ALU_NOP, ALU_SEL_NOP, P0_NO, P1_NO, W_NO, IMM_NONE, EXC_INE);
    add_row(F_ZERO, 17'h000, ALU_NOP, ALU_SEL_NOP, P0_NO, P1_NO, W_NO, IMM_NONE); // Bubble
endtask

`endif

/* dv/tb_la32_decode.sv */
module tb_la32_decode;
    import la32_isa_pkg::*;
    import decode_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int TIMEOUT    = 20;
    localparam int PASSES     = 3;

    logic        clk;
    logic        arst_n_i;
    logic        valid_i;
    logic [31:0] pc_i;
    inst_w_t     inst_i;
    logic        valid_o;
    logic [31:0] pc_o;
    alu_op_e     alu_op_o;
    alu_sel_e    alu_sel_o;
    logic [1:0]  rf_re_o;
    reg_addr_t   rf_raddr0_o;
    reg_addr_t   rf_raddr1_o;
    logic        rf_we_o;
    reg_addr_t   rf_waddr_o;
    logic [31:0] imm_o;
    logic        exc_o;
    exc_cause_e  exc_cause_o;

    `include "decode_vectors.svh"

    typedef struct packed {
        logic        valid;
        logic [5:0]  row;
        logic [31:0] word;
        logic [31:0] pc;
    } pend_t;

    pend_t       pipe_q [$]; // Driven items awaiting their output

    la32_decode_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] build_word(input vec_t v, input logic [31:0] rnd);
        case (v.fmt)
            F_3R:    return {v.opcode, rnd[14:0]};
            F_2RI12: return {v.opcode[9:0], rnd[21:0]};
            F_1RI20: return {v.opcode[6:0], rnd[24:0]};
            F_OFFS:  return {v.opcode[5:0], rnd[25:0]};
            default: return 32'd0;
        endcase
    endfunction

    // Immediate rules straight from the ISA field layout
    function automatic logic [31:0] expected_imm(input imm_kind_e kind, input logic [31:0] w);
        case (kind)
            IMM_SI12:    return 32'($signed(w[21:10]));
            IMM_UI12:    return {20'd0, w[21:10]};
            IMM_UI5:     return {27'd0, w[14:10]};
            IMM_SI20_HI: return {w[24:5], 12'd0};
            IMM_OFFS16:  return 32'($signed(w[25:10])) << 2;
            IMM_OFFS26:  return 32'($signed({w[9:0], w[25:10]})) << 2;
            default:     return 32'd0;
        endcase
    endfunction

    task automatic check_idle();
        check_value("valid_o", 32'd0, 32'(valid_o));
        check_value("alu_op_o", 32'(ALU_NOP), 32'(alu_op_o));
        check_value("alu_sel_o", 32'(ALU_SEL_NOP), 32'(alu_sel_o));
        check_value("rf_re_o", 32'd0, 32'(rf_re_o));
        check_value("rf_we_o", 32'd0, 32'(rf_we_o));
        check_value("exc_o", 32'd0, 32'(exc_o));
    endtask

    task automatic check_item(input pend_t p);
        vec_t       v;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        logic [1:0] re;
        if (!p.valid) begin
            check_idle();
        end else begin
            v  = vec_tbl[p.row];
            rd = p.word[4:0];
            rj = p.word[9:5];
            rk = p.word[14:10];
            re = {v.p1 != P1_NO, v.p0 != P0_NO};
            check_value("valid_o", 32'd1, 32'(valid_o));
            check_value("pc_o", p.pc, pc_o);
            check_value("alu_op_o", 32'(v.alu_op), 32'(alu_op_o));
            check_value("alu_sel_o", 32'(v.alu_sel), 32'(alu_sel_o));
            check_value("rf_re_o", 32'(re), 32'(rf_re_o));
            check_value("rf_we_o", 32'(v.wr != W_NO), 32'(rf_we_o));
            check_value("imm_o", expected_imm(v.imm_kind, p.word), imm_o);
            check_value("exc_o", 32'(v.exc_cause != EXC_NONE), 32'(exc_o));
            check_value("exc_cause_o", 32'(v.exc_cause), 32'(exc_cause_o));
            if (v.p0 == P0_RJ) check_value("rf_raddr0_o", 32'(rj), 32'(rf_raddr0_o));
            if (v.p0 == P0_R0) check_value("rf_raddr0_o", 32'd0, 32'(rf_raddr0_o));
            if (v.p1 == P1_RK) check_value("rf_raddr1_o", 32'(rk), 32'(rf_raddr1_o));
            if (v.p1 == P1_RD) check_value("rf_raddr1_o", 32'(rd), 32'(rf_raddr1_o));
            if (v.wr == W_RD) check_value("rf_waddr_o", 32'(rd), 32'(rf_waddr_o));
            if (v.wr == W_R1) check_value("rf_waddr_o", 32'd1, 32'(rf_waddr_o)); // Link reg
        end
    endtask

    task automatic drive_slot(input logic vld, input int row);
        pend_t       p;
        logic [31:0] rnd;
        rnd     = $urandom;
        p.valid = vld;
        p.row   = row[5:0];
        p.pc    = $urandom & 32'hffff_fffc;
        p.word  = vld ? build_word(vec_tbl[row], rnd) : rnd; // Gap carries junk
        valid_i = vld;
        pc_i    = p.pc;
        inst_i  = p.word;
        pipe_q.push_back(p);
    endtask

    task automatic stream_slot(input logic vld, input int row);
        if (pipe_q.size() == 2) check_item(pipe_q.pop_front());
        drive_slot(vld, row);
        next_cycle();
    endtask

    initial begin
        int cycles;
        arst_n_i  = 1'b0;
        valid_i   = 1'b0;
        pc_i      = 32'd0;
        inst_i    = 32'd0;
        void'($urandom(33));
        load_vectors();

        repeat (2) begin
            next_cycle();
            check_idle();
        end
        arst_n_i = 1'b1;
        next_cycle();
        check_idle();

        // Latency of a single instruction
        drive_slot(1'b1, 0);
        next_cycle();
        valid_i = 1'b0;
        cycles  = 1;
        while (valid_o !== 1'b1) begin
            if (cycles >= TIMEOUT) begin
                $display("Timeout: valid_o never rose after a single instruction");
                stop_on_failure();
            end
            next_cycle();
            cycles++;
        end
        check_value("latency", 32'd2, cycles);
        check_item(pipe_q.pop_front());
        pipe_q.delete();

        // First pass back to back and later passes with random gaps
        for (int pass = 0; pass < PASSES; pass++) begin
            for (int i = 0; i < NUM_VECS; i++) begin
                if (pass > 0 && (i == 0 || $urandom_range(3, 0) == 0)) begin
                    stream_slot(1'b0, 0);
                end
                stream_slot(1'b1, i);
            end
        end
        repeat (2) stream_slot(1'b0, 0);
        pipe_q.delete();

        $display("Verification passed");
        $finish;
    end

endmodule

/* la32_decode.f */
+incdir+include
verilog/la32_isa_pkg.sv
verilog/decode_pkg.sv
verilog/dec_if.sv
verilog/fetch_latch.sv
verilog/inst_decoder.sv
verilog/imm_gen.sv
verilog/dispatch_reg.sv
verilog/la32_decode_top.sv
dv/tb_la32_decode.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_la32_decode \
    -f la32_decode.f -o tb_la32_decode_sim > build.log 2>&1 \
    || { cat build.log; echo "Build step failed"; exit 1; }

./obj_dir/tb_la32_decode_sim > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

/* verilog/dec_if.sv */
interface dec_if;
    import la32_isa_pkg::*;
    import decode_pkg::*;

    logic                 valid;
    logic [31:0]          pc;
    alu_op_e              alu_op;
    alu_sel_e             alu_sel;
    logic [1:0]           rf_re;    // Bit 0 is port 0
    reg_addr_t [1:0]      rf_raddr;
    logic                 rf_we;
    reg_addr_t            rf_waddr;
    logic [31:0]          imm;
    logic                 exc;
    exc_cause_e           exc_cause;

    modport dec_mp (
        output valid, pc, alu_op, alu_sel, rf_re, rf_raddr,
        output rf_we, rf_waddr, exc, exc_cause
    );

    modport imm_mp (
        output imm
    );

    modport sink_mp (
        input valid, pc, alu_op, alu_sel, rf_re, rf_raddr,
        input rf_we, rf_waddr, imm, exc, exc_cause
    );

endinterface

/* verilog/decode_pkg.sv */
package decode_pkg;

    typedef enum logic [5:0] {
        ALU_NOP,
        ALU_ADDW,
        ALU_SUBW,
        ALU_SLT,
        ALU_SLTU,
        ALU_NOR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLLW,
        ALU_SRLW,
        ALU_SRAW,
        ALU_SLTI,
        ALU_SLTUI,
        ALU_ADDIW,
        ALU_ANDI,
        ALU_ORI,
        ALU_XORI,
        ALU_SLLIW,
        ALU_SRLIW,
        ALU_SRAIW,
        ALU_LU12I,
        ALU_PCADDU12I,
        ALU_LDB,
        ALU_LDH,
        ALU_LDW,
        ALU_LDBU,
        ALU_LDHU,
        ALU_STB,
        ALU_STH,
        ALU_STW,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_B,
        ALU_BL,
        ALU_JIRL,
        ALU_BREAK,
        ALU_SYSCALL
    } alu_op_e;

    typedef enum logic [2:0] {
        ALU_SEL_NOP,
        ALU_SEL_ARITH,
        ALU_SEL_LOGIC,
        ALU_SEL_SHIFT,
        ALU_SEL_LDST,
        ALU_SEL_BRANCH
    } alu_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_SI12,
        IMM_UI12,
        IMM_UI5,
        IMM_SI20_HI,
        IMM_OFFS16,
        IMM_OFFS26
    } imm_kind_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_INE,
        EXC_BRK,
        EXC_SYS
    } exc_cause_e;

endpackage

/* verilog/dispatch_reg.sv */
module dispatch_reg (
    input  logic                     clk,
    input  logic                     arst_n_i,
    dec_if.sink_mp                   dec,
    output logic                     valid_o,
    output logic [31:0]              pc_o,
    output decode_pkg::alu_op_e      alu_op_o,
    output decode_pkg::alu_sel_e     alu_sel_o,
    output logic [1:0]               rf_re_o,
    output la32_isa_pkg::reg_addr_t  rf_raddr0_o,
    output la32_isa_pkg::reg_addr_t  rf_raddr1_o,
    output logic                     rf_we_o,
    output la32_isa_pkg::reg_addr_t  rf_waddr_o,
    output logic [31:0]              imm_o,
    output logic                     exc_o,
    output decode_pkg::exc_cause_e   exc_cause_o
);
    import decode_pkg::*;

    // Control fields; decoder already masks them in bubble cycles
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o     <= 1'b0;
            alu_op_o    <= ALU_NOP;
            alu_sel_o   <= ALU_SEL_NOP;
            rf_re_o     <= 2'b00;
            rf_we_o     <= 1'b0;
            exc_o       <= 1'b0;
            exc_cause_o <= EXC_NONE;
        end else begin
            valid_o     <= dec.valid;
            alu_op_o    <= dec.alu_op;
            alu_sel_o   <= dec.alu_sel;
            rf_re_o     <= dec.rf_re;
            rf_we_o     <= dec.rf_we;
            exc_o       <= dec.exc;
            exc_cause_o <= dec.exc_cause;
        end
    end

    always_ff @(posedge clk) begin
        pc_o        <= dec.pc;
        rf_raddr0_o <= dec.rf_raddr[0];
        rf_raddr1_o <= dec.rf_raddr[1];
        rf_waddr_o  <= dec.rf_waddr;
        imm_o       <= dec.imm;
    end

endmodule

/* verilog/fetch_latch.sv */
module fetch_latch (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  valid_i,
    input  logic [31:0]           pc_i,
    input  la32_isa_pkg::inst_w_t inst_i,
    output logic                  valid_o,
    output logic [31:0]           pc_o,
    output la32_isa_pkg::inst_u   inst_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // A bubble keeps the last fetched word
    always_ff @(posedge clk) begin
        if (valid_i) begin
            pc_o   <= pc_i;
            inst_o <= inst_i;
        end
    end

endmodule

/* verilog/imm_gen.sv */
module imm_gen (
    input  la32_isa_pkg::inst_u    inst_i,
    input  decode_pkg::imm_kind_e  imm_kind_i,
    dec_if.imm_mp                  dec
);
    import decode_pkg::*;

    logic [11:0] i12;
    logic [15:0] offs16;
    logic [25:0] offs26;

    assign i12    = inst_i.fmt_2ri12.i12;
    assign offs16 = inst_i.fmt_offs.offs16;
    assign offs26 = {inst_i.fmt_offs.rj, inst_i.fmt_offs.rd, offs16}; // High part in rj/rd

    always_comb begin
        case (imm_kind_i)
            IMM_SI12: begin
                dec.imm = {{20{i12[11]}}, i12};
            end
            IMM_UI12: begin
                dec.imm = {20'b0, i12};
            end
            IMM_UI5: begin
                dec.imm = {27'b0, inst_i.fmt_3r.rk};
            end
            IMM_SI20_HI: begin
                dec.imm = {inst_i.fmt_1ri20.i20, 12'b0};
            end
            IMM_OFFS16: begin
                dec.imm = {{14{offs16[15]}}, offs16, 2'b00}; // Word offset
            end
            IMM_OFFS26: begin
                dec.imm = {{4{offs26[25]}}, offs26, 2'b00};
            end
            default: begin
                dec.imm = 32'b0;
            end
        endcase
    end

endmodule

/* verilog/inst_decoder.sv */
module inst_decoder (
    input  logic                   valid_i,
    input  logic [31:0]            pc_i,
    input  la32_isa_pkg::inst_u    inst_i,
    output decode_pkg::imm_kind_e  imm_kind_o,
    dec_if.dec_mp                  dec
);
    import la32_isa_pkg::*;
    import decode_pkg::*;

    alu_op_e   op;
    reg_addr_t rj;
    reg_addr_t rk;
    reg_addr_t rd;

    assign rj = inst_i.fmt_3r.rj;
    assign rk = inst_i.fmt_3r.rk;
    assign rd = inst_i.fmt_3r.rd;

    assign dec.valid = valid_i;
    assign dec.pc    = pc_i;

    // Opcode match, formats never alias for the kept set
    always_comb begin
        op = ALU_NOP;
        case (inst_i.fmt_2ri12.op10)
            SLTI_OP:  op = ALU_SLTI;
            SLTUI_OP: op = ALU_SLTUI;
            ADDIW_OP: op = ALU_ADDIW;
            ANDI_OP:  op = ALU_ANDI;
            ORI_OP:   op = ALU_ORI;
            XORI_OP:  op = ALU_XORI;
            LDB_OP:   op = ALU_LDB;
            LDH_OP:   op = ALU_LDH;
            LDW_OP:   op = ALU_LDW;
            STB_OP:   op = ALU_STB;
            STH_OP:   op = ALU_STH;
            STW_OP:   op = ALU_STW;
            LDBU_OP:  op = ALU_LDBU;
            LDHU_OP:  op = ALU_LDHU;
            default:  ;
        endcase
        case (inst_i.fmt_3r.op17)
            ADDW_OP:    op = ALU_ADDW;
            SUBW_OP:    op = ALU_SUBW;
            SLT_OP:     op = ALU_SLT;
            SLTU_OP:    op = ALU_SLTU;
            NOR_OP:     op = ALU_NOR;
            AND_OP:     op = ALU_AND;
            OR_OP:      op = ALU_OR;
            XOR_OP:     op = ALU_XOR;
            SLLW_OP:    op = ALU_SLLW;
            SRLW_OP:    op = ALU_SRLW;
            SRAW_OP:    op = ALU_SRAW;
            BREAK_OP:   op = ALU_BREAK;
            SYSCALL_OP: op = ALU_SYSCALL;
            SLLIW_OP:   op = ALU_SLLIW;
            SRLIW_OP:   op = ALU_SRLIW;
            SRAIW_OP:   op = ALU_SRAIW;
            default:    ;
        endcase
        case (inst_i.fmt_1ri20.op7)
            LU12I_OP:     op = ALU_LU12I;
            PCADDU12I_OP: op = ALU_PCADDU12I;
            default:      ;
        endcase
        case (inst_i.fmt_offs.op6)
            JIRL_OP: op = ALU_JIRL;
            B_OP:    op = ALU_B;
            BL_OP:   op = ALU_BL;
            BEQ_OP:  op = ALU_BEQ;
            BNE_OP:  op = ALU_BNE;
            BLT_OP:  op = ALU_BLT;
            BGE_OP:  op = ALU_BGE;
            BLTU_OP: op = ALU_BLTU;
            BGEU_OP: op = ALU_BGEU;
            default: ;
        endcase
    end

    always_comb begin
        dec.alu_op      = op;
        dec.alu_sel     = ALU_SEL_NOP;
        imm_kind_o      = IMM_NONE;
        dec.rf_re       = 2'b00;
        dec.rf_raddr[0] = rj;
        dec.rf_raddr[1] = rk;
        dec.rf_we       = 1'b0;
        dec.rf_waddr    = rd;
        dec.exc         = 1'b0;
        dec.exc_cause   = EXC_NONE;

        case (op)
            ALU_ADDW, ALU_SUBW, ALU_SLT, ALU_SLTU: begin
                dec.alu_sel = ALU_SEL_ARITH;
                dec.rf_re   = 2'b11;
                dec.rf_we   = 1'b1;
            end
            ALU_NOR, ALU_AND, ALU_OR, ALU_XOR: begin
                dec.alu_sel = ALU_SEL_LOGIC;
                dec.rf_re   = 2'b11;
                dec.rf_we   = 1'b1;
            end
            ALU_SLLW, ALU_SRLW, ALU_SRAW: begin
                dec.alu_sel = ALU_SEL_SHIFT;
                dec.rf_re   = 2'b11;
                dec.rf_we   = 1'b1;
            end
            ALU_SLTI, ALU_SLTUI, ALU_ADDIW, ALU_PCADDU12I: begin
                dec.alu_sel = ALU_SEL_ARITH;
                imm_kind_o  = (op == ALU_PCADDU12I) ? IMM_SI20_HI : IMM_SI12;
                dec.rf_re   = 2'b01;
                dec.rf_we   = 1'b1;
            end
            ALU_ANDI, ALU_ORI, ALU_XORI: begin
                dec.alu_sel = ALU_SEL_LOGIC;
                imm_kind_o  = IMM_UI12;
                dec.rf_re   = 2'b01;
                dec.rf_we   = 1'b1;
            end
            ALU_SLLIW, ALU_SRLIW, ALU_SRAIW: begin
                dec.alu_sel = ALU_SEL_SHIFT;
                imm_kind_o  = IMM_UI5;
                dec.rf_re   = 2'b01;
                dec.rf_we   = 1'b1;
            end
            ALU_LU12I: begin
                dec.alu_sel     = ALU_SEL_LOGIC;
                imm_kind_o      = IMM_SI20_HI;
                dec.rf_re       = 2'b01;
                dec.rf_raddr[0] = '0; // r0 + imm
                dec.rf_we       = 1'b1;
            end
            ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU: begin
                dec.alu_sel = ALU_SEL_LDST;
                imm_kind_o  = IMM_SI12;
                dec.rf_re   = 2'b01;
                dec.rf_we   = 1'b1;
            end
            ALU_STB, ALU_STH, ALU_STW: begin
                dec.alu_sel     = ALU_SEL_LDST;
                imm_kind_o      = IMM_SI12;
                dec.rf_re       = 2'b11;
                dec.rf_raddr[1] = rd; // Store data
            end
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: begin
                dec.alu_sel     = ALU_SEL_BRANCH;
                imm_kind_o      = IMM_OFFS16;
                dec.rf_re       = 2'b11;
                dec.rf_raddr[1] = rd;
            end
            ALU_B, ALU_BL: begin
                dec.alu_sel  = ALU_SEL_BRANCH;
                imm_kind_o   = IMM_OFFS26;
                dec.rf_we    = (op == ALU_BL);
                dec.rf_waddr = (op == ALU_BL) ? REG_RA : rd;
            end
            ALU_JIRL: begin
                dec.alu_sel = ALU_SEL_BRANCH;
                imm_kind_o  = IMM_OFFS16;
                dec.rf_re   = 2'b01;
                dec.rf_we   = 1'b1;
            end
            ALU_BREAK: begin
                dec.exc       = 1'b1;
                dec.exc_cause = EXC_BRK;
            end
            ALU_SYSCALL: begin
                dec.exc       = 1'b1;
                dec.exc_cause = EXC_SYS;
            end
            default: begin
                if (inst_i != '0) begin // Zero word is a bubble
                    dec.exc       = 1'b1;
                    dec.exc_cause = EXC_INE;
                end
            end
        endcase

        if (!valid_i) begin
            dec.alu_op    = ALU_NOP;
            dec.alu_sel   = ALU_SEL_NOP;
            imm_kind_o    = IMM_NONE;
            dec.rf_re     = 2'b00;
            dec.rf_we     = 1'b0;
            dec.exc       = 1'b0;
            dec.exc_cause = EXC_NONE;
        end
    end

endmodule

/* verilog/la32_decode_top.sv */
module la32_decode_top (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     valid_i,
    input  logic [31:0]              pc_i,
    input  la32_isa_pkg::inst_w_t    inst_i,
    output logic                     valid_o,
    output logic [31:0]              pc_o,
    output decode_pkg::alu_op_e      alu_op_o,
    output decode_pkg::alu_sel_e     alu_sel_o,
    output logic [1:0]               rf_re_o,
    output la32_isa_pkg::reg_addr_t  rf_raddr0_o,
    output la32_isa_pkg::reg_addr_t  rf_raddr1_o,
    output logic                     rf_we_o,
    output la32_isa_pkg::reg_addr_t  rf_waddr_o,
    output logic [31:0]              imm_o,
    output logic                     exc_o,
    output decode_pkg::exc_cause_e   exc_cause_o
);
    import la32_isa_pkg::*;
    import decode_pkg::*;

    logic        fetch_valid;
    logic [31:0] fetch_pc;
    inst_u       fetch_inst;
    imm_kind_e   imm_kind;

    dec_if u_dec_if ();

    fetch_latch u_fetch_latch (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .pc_i     (pc_i),
        .inst_i   (inst_i),
        .valid_o  (fetch_valid),
        .pc_o     (fetch_pc),
        .inst_o   (fetch_inst)
    );

    inst_decoder u_inst_decoder (
        .valid_i    (fetch_valid),
        .pc_i       (fetch_pc),
        .inst_i     (fetch_inst),
        .imm_kind_o (imm_kind),
        .dec        (u_dec_if.dec_mp)
    );

    imm_gen u_imm_gen (
        .inst_i     (fetch_inst),
        .imm_kind_i (imm_kind),
        .dec        (u_dec_if.imm_mp)
    );

    // Second pipeline register toward execute
    dispatch_reg u_dispatch_reg (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .dec         (u_dec_if.sink_mp),
        .valid_o     (valid_o),
        .pc_o        (pc_o),
        .alu_op_o    (alu_op_o),
        .alu_sel_o   (alu_sel_o),
        .rf_re_o     (rf_re_o),
        .rf_raddr0_o (rf_raddr0_o),
        .rf_raddr1_o (rf_raddr1_o),
        .rf_we_o     (rf_we_o),
        .rf_waddr_o  (rf_waddr_o),
        .imm_o       (imm_o),
        .exc_o       (exc_o),
        .exc_cause_o (exc_cause_o)
    );

endmodule

/* verilog/la32_isa_pkg.sv */
package la32_isa_pkg;

    localparam int INST_W = 32;

    typedef logic [INST_W-1:0] inst_w_t;
    typedef logic [4:0] reg_addr_t;

    localparam reg_addr_t REG_RA = 5'd1; // Link register for BL

    typedef struct packed {
        logic [16:0] op17;
        reg_addr_t   rk;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  op10;
        logic [11:0] i12;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [6:0]  op7;
        logic [19:0] i20;
        reg_addr_t   rd;
    } fmt_1ri20_t;

    // For B and BL the upper offs26 bits sit in the rj/rd slots
    typedef struct packed {
        logic [5:0]  op6;
        logic [15:0] offs16;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_offs_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_1ri20_t fmt_1ri20;
        fmt_offs_t  fmt_offs;
    } inst_u;

    localparam logic [9:0] SLTI_OP   = 10'h008;
    localparam logic [9:0] SLTUI_OP  = 10'h009;
    localparam logic [9:0] ADDIW_OP  = 10'h00a;
    localparam logic [9:0] ANDI_OP   = 10'h00d;
    localparam logic [9:0] ORI_OP    = 10'h00e;
    localparam logic [9:0] XORI_OP   = 10'h00f;
    localparam logic [9:0] LDB_OP    = 10'h0a0;
    localparam logic [9:0] LDH_OP    = 10'h0a1;
    localparam logic [9:0] LDW_OP    = 10'h0a2;
    localparam logic [9:0] STB_OP    = 10'h0a4;
    localparam logic [9:0] STH_OP    = 10'h0a5;
    localparam logic [9:0] STW_OP    = 10'h0a6;
    localparam logic [9:0] LDBU_OP   = 10'h0a8;
    localparam logic [9:0] LDHU_OP   = 10'h0a9;

    localparam logic [16:0] ADDW_OP    = 17'h00020;
    localparam logic [16:0] SUBW_OP    = 17'h00022;
    localparam logic [16:0] SLT_OP     = 17'h00024;
    localparam logic [16:0] SLTU_OP    = 17'h00025;
    localparam logic [16:0] NOR_OP     = 17'h00028;
    localparam logic [16:0] AND_OP     = 17'h00029;
    localparam logic [16:0] OR_OP      = 17'h0002a;
    localparam logic [16:0] XOR_OP     = 17'h0002b;
    localparam logic [16:0] SLLW_OP    = 17'h0002e;
    localparam logic [16:0] SRLW_OP    = 17'h0002f;
    localparam logic [16:0] SRAW_OP    = 17'h00030;
    localparam logic [16:0] BREAK_OP   = 17'h00054;
    localparam logic [16:0] SYSCALL_OP = 17'h00056;
    localparam logic [16:0] SLLIW_OP   = 17'h00081;
    localparam logic [16:0] SRLIW_OP   = 17'h00089;
    localparam logic [16:0] SRAIW_OP   = 17'h00091;

    localparam logic [6:0] LU12I_OP     = 7'h0a;
    localparam logic [6:0] PCADDU12I_OP = 7'h0e;

    localparam logic [5:0] JIRL_OP = 6'h13;
    localparam logic [5:0] B_OP    = 6'h14;
    localparam logic [5:0] BL_OP   = 6'h15;
    localparam logic [5:0] BEQ_OP  = 6'h16;
    localparam logic [5:0] BNE_OP  = 6'h17;
    localparam logic [5:0] BLT_OP  = 6'h18;
    localparam logic [5:0] BGE_OP  = 6'h19;
    localparam logic [5:0] BLTU_OP = 6'h1a;
    localparam logic [5:0] BGEU_OP = 6'h1b;

endpackage
